// ==== compile.f ====
+incdir+verilog
verilog/ig_pkg.sv
verilog/ig_pixel_counter.sv
verilog/ig_ctrl_fsm.sv
verilog/ig_line_window.sv
verilog/ig_grad_engine.sv
verilog/ig_top.sv
tb/ig_clk_gen.sv
tb/ig_assertions.sv
tb/ig_tb.sv

// ==== Makefile ====
# Verilator build for the image gradient engine
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP ?= ig_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Testbench passed
COMMON_FLAGS ?= --timing --assert --timescale 1ns/10ps
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/ig_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "ig_params.svh"

module ig_tb;

    import ig_pkg::*;

    localparam int NUM_PIX = `IG_WIDTH * `IG_HEIGHT;
    // twice the latency from reset release to done
    localparam int TIMEOUT_CYCLES = 2 * (NUM_PIX + `IG_WIDTH + 4);

    logic clk;
    logic reset;
    pixel_t img_di = '0;
    logic img_rd;
    addr_t img_addr;
    logic grad_wr;
    addr_t grad_addr;
    grad_word_t grad_do;
    logic done;

    // image memory and gradient write counts over the full address space
    pixel_t image [2**`IG_ADDR_W];
    int write_count [2**`IG_ADDR_W] = '{default: 0};

    logic rd_pending = 1'b0;
    addr_t rd_addr = '0;
    int next_rd_addr = 0;
    int next_wr_addr = 0;
    int cycle_count = 0;
    logic done_seen = 1'b0;
    logic [31:0] rng_state;

    ig_clk_gen u_clk_gen (
        .clk(clk),
        .reset(reset)
    );

    ig_top dut (
        .clk(clk),
        .reset(reset),
        .img_di(img_di),
        .img_rd(img_rd),
        .img_addr(img_addr),
        .grad_wr(grad_wr),
        .grad_addr(grad_addr),
        .grad_do(grad_do),
        .done(done)
    );

    bind ig_top ig_assertions u_assertions (
        .clk(clk),
        .reset(reset),
        .img_rd(img_rd),
        .img_addr(img_addr),
        .grad_wr(grad_wr),
        .done(done)
    );

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected word from the frame rules
    // zero on the last column and the last row
    function automatic logic [31:0] expected_word(input int a);
        int x;
        int y;
        int gx;
        int gy;
        x = a % `IG_WIDTH;
        y = a / `IG_WIDTH;
        if (x == `IG_WIDTH - 1 || y == `IG_HEIGHT - 1) begin
            return 32'd0;
        end
        // differences to the right neighbour and to the pixel below
        gx = int'(image[addr_t'(a + 1)]) - int'(image[addr_t'(a)]);
        gy = int'(image[addr_t'(a + `IG_WIDTH)]) - int'(image[addr_t'(a)]);
        return 32'({gx[`IG_GRAD_W-1:0], gy[`IG_GRAD_W-1:0]});
    endfunction

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0t: %s", $time, reason);
        stop_run();
    endtask

    task automatic check_value(input string what, input int addr,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s at address %0d, got 0x%0h, expected 0x%0h",
                     $time, what, addr, got, exp);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------------
    // image memory answers one cycle after the request
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        rd_pending = img_rd;
        rd_addr = img_addr;
    end

    always @(posedge clk) begin
        #1;
        if (rd_pending) begin
            img_di = image[rd_addr];
        end
    end

    // ------------------------------------------------------------------
    // monitor on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            if (img_rd !== 1'b0 || grad_wr !== 1'b0 || done !== 1'b0) begin
                abort_run("outputs not idle during reset");
            end
        end else begin
            if (img_rd && done) begin
                abort_run("image read issued after done");
            end
            if (grad_wr && done) begin
                abort_run("gradient write issued after done");
            end
            if (done_seen && !done) begin
                abort_run("done dropped before reset");
            end
            // reads in raster order
            if (img_rd) begin
                check_value("read address", next_rd_addr, 32'(img_addr),
                            32'(next_rd_addr));
                next_rd_addr++;
            end
            // each write checked as it lands
            if (grad_wr) begin
                check_value("write address", next_wr_addr, 32'(grad_addr),
                            32'(next_wr_addr));
                check_value("gradient word", int'(grad_addr), 32'(grad_do),
                            expected_word(int'(grad_addr)));
                write_count[grad_addr]++;
                next_wr_addr++;
            end
            if (done) begin
                done_seen = 1'b1;
            end
        end
    end

    // cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES && !done_seen) begin
            abort_run($sformatf("timeout, done not raised within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        $timeformat(-9, 1, " ns", 0);
        rng_state = 32'd43898;
        for (int k = 0; k < NUM_PIX; k++) begin
            rng_state = xorshift32(rng_state);
            image[addr_t'(k)] = pixel_t'(rng_state >> 8);
        end

        wait (done_seen);
        // a few more cycles so the monitor sees done held
        repeat (4) @(negedge clk);

        // every address written exactly once
        for (int k = 0; k < NUM_PIX; k++) begin
            check_value("write count", k, 32'(write_count[addr_t'(k)]), 32'd1);
        end
        check_value("reads issued", NUM_PIX, 32'(next_rd_addr), 32'(NUM_PIX));

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ig_assertions.sv ====
`default_nettype none
`timescale 1ns/10ps

module ig_assertions (
    input wire clk,
    input wire reset,
    input wire logic img_rd,
    input wire ig_pkg::addr_t img_addr,
    input wire logic grad_wr,
    input wire logic done
);

    // ------------------------------------------------------------------
    // reset release
    // ------------------------------------------------------------------
    // nothing active when reset drops
    idle_at_release: assert property (@(posedge clk)
        $fell(reset) |-> !img_rd && !grad_wr && !done)
        else $error("outputs active at reset release");

    // first read right after release, at address 0
    read_starts: assert property (@(posedge clk)
        $fell(reset) |=> img_rd && (img_addr == '0))
        else $error("first image read missing or not at address 0");

    // ------------------------------------------------------------------
    // read sweep
    // ------------------------------------------------------------------
    // back to back reads step by one
    addr_steps: assert property (@(posedge clk) disable iff (reset)
        img_rd && $past(img_rd) |-> img_addr == $past(img_addr) + 1'b1)
        else $error("image address did not step by one");

    // ------------------------------------------------------------------
    // completion
    // ------------------------------------------------------------------
    // sticky until reset
    done_holds: assert property (@(posedge clk) disable iff (reset)
        done |=> done)
        else $error("done dropped without reset");

    // memories quiet once finished
    quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !img_rd && !grad_wr)
        else $error("memory access after done");

endmodule

`default_nettype wire

// ==== tb/ig_clk_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module ig_clk_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 4 rising edges, released just after the edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/ig_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module ig_top (
    input wire clk,
    input wire reset,
    input wire ig_pkg::pixel_t img_di,
    output logic img_rd,
    output ig_pkg::addr_t img_addr,
    output logic grad_wr,
    output ig_pkg::addr_t grad_addr,
    output ig_pkg::grad_word_t grad_do,
    output logic done
);

    import ig_pkg::*;

    pixel_pos_t pos;
    logic last;
    logic count_en;
    logic count_clear;
    logic flush;

    // read data alignment, one cycle behind the request
    logic pix_valid;
    pixel_pos_t pix_pos;

    pixel_t cur;
    pixel_t up;
    pixel_t right_up;
    grad_req_t grad_req;

    // ------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------
    ig_pixel_counter u_counter (
        .clk(clk),
        .reset(reset),
        .count_en(count_en),
        .count_clear(count_clear),
        .pos(pos),
        .last(last)
    );

    ig_ctrl_fsm u_fsm (
        .clk(clk),
        .reset(reset),
        .last(last),
        .img_rd(img_rd),
        .count_en(count_en),
        .count_clear(count_clear),
        .flush(flush),
        .done(done)
    );

    assign img_addr = pos.addr;

    // img_di valid the cycle after img_rd
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= img_rd;
        end
    end

    always_ff @(posedge clk) begin
        pix_pos <= pos;
    end

    // ------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------
    ig_line_window u_window (
        .clk(clk),
        .reset(reset),
        .shift(pix_valid),
        .pix_in(img_di),
        .cur(cur),
        .up(up),
        .right_up(right_up)
    );

    ig_grad_engine u_engine (
        .clk(clk),
        .reset(reset),
        .pix_valid(pix_valid),
        .pix_pos(pix_pos),
        .flush(flush),
        .cur(cur),
        .up(up),
        .right_up(right_up),
        .grad_req(grad_req)
    );

    // gradient memory port
    assign grad_wr = grad_req.wr;
    assign grad_addr = grad_req.addr;
    assign grad_do = grad_req.word;

endmodule

`default_nettype wire

// ==== verilog/ig_grad_engine.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "ig_params.svh"

module ig_grad_engine (
    input wire clk,
    input wire reset,
    input wire logic pix_valid,
    input wire ig_pkg::pixel_pos_t pix_pos,
    input wire logic flush,
    input wire ig_pkg::pixel_t cur,
    input wire ig_pkg::pixel_t up,
    input wire ig_pkg::pixel_t right_up,
    output ig_pkg::grad_req_t grad_req
);

    import ig_pkg::*;

    grad_t gx_diff;
    grad_t gy_diff;
    logic row_ready;
    logic last_col;
    grad_req_t req_next;

    // ------------------------------------------------------------------
    // differences
    // ------------------------------------------------------------------
    // pixels zero extended, 10 bits hold -255..255
    assign gx_diff = grad_t'(right_up) - grad_t'(up);
    assign gy_diff = grad_t'(cur) - grad_t'(up);

    // pixel below target has arrived once past row 0
    assign row_ready = (pix_pos.y != '0);

    // target sits in same column as incoming pixel
    assign last_col = (pix_pos.x == coord_t'(`IG_WIDTH - 1));

    // ------------------------------------------------------------------
    // request build
    // ------------------------------------------------------------------
    always_comb begin
        req_next = '0;
        if (flush) begin
            // last row, word stays zero
            req_next.wr = 1'b1;
            req_next.addr = pix_pos.addr;
        end else if (pix_valid && row_ready) begin
            req_next.wr = 1'b1;
            // one row above the pixel just read
            req_next.addr = pix_pos.addr - addr_t'(`IG_WIDTH);
            if (!last_col) begin
                req_next.word.gx = gx_diff;
                req_next.word.gy = gy_diff;
            end
        end
    end

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_req.wr <= 1'b0;
        end else begin
            grad_req <= req_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ig_line_window.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "ig_params.svh"

module ig_line_window (
    input wire clk,
    input wire reset,
    input wire logic shift,
    input wire ig_pkg::pixel_t pix_in,
    output ig_pkg::pixel_t cur,
    output ig_pkg::pixel_t up,
    output ig_pkg::pixel_t right_up
);

    import ig_pkg::*;

    // one full row of history, index 0 is the newest stored pixel
    pixel_t line_q [`IG_WIDTH];

    // ------------------------------------------------------------------
    // row delay line
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `IG_WIDTH; k++) begin
                line_q[k] <= '0;
            end
        end else if (shift) begin
            line_q[0] <= pix_in;
            for (int k = 1; k < `IG_WIDTH; k++) begin
                line_q[k] <= line_q[k-1];
            end
        end
    end

    // ------------------------------------------------------------------
    // taps
    // ------------------------------------------------------------------
    // incoming pixel is the newest element of the window
    assign cur = pix_in;

    // exactly one row back
    assign up = line_q[`IG_WIDTH-1];

    // one row back, one column right
    assign right_up = line_q[`IG_WIDTH-2];

endmodule

`default_nettype wire

// ==== verilog/ig_ctrl_fsm.sv ====
`default_nettype none
`timescale 1ns/10ps

module ig_ctrl_fsm (
    input wire clk,
    input wire reset,
    input wire logic last,
    output logic img_rd,
    output logic count_en,
    output logic count_clear,
    output logic flush,
    output logic done
);

    import ig_pkg::*;

    ig_state_t state;

    // ------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------
    // read   one address per cycle over the whole frame
    // drain  last pixel still in flight, reload counter
    // flush  zero words for the last row
    // done   held until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_READ;
            img_rd <= 1'b0;
            count_en <= 1'b0;
            count_clear <= 1'b0;
            flush <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                S_READ: begin
                    if (img_rd && last) begin
                        // final address goes out this cycle
                        state <= S_DRAIN;
                        img_rd <= 1'b0;
                        count_en <= 1'b0;
                        count_clear <= 1'b1;
                    end else begin
                        img_rd <= 1'b1;
                        count_en <= 1'b1;
                    end
                end

                S_DRAIN: begin
                    // counter now at start of last row
                    state <= S_FLUSH;
                    count_clear <= 1'b0;
                    count_en <= 1'b1;
                end

                S_FLUSH: begin
                    // flush trails count_en by one, lines up with pix_pos
                    count_en <= count_en && !last;
                    flush <= count_en;
                    if (flush && !count_en) begin
                        state <= S_DONE;
                    end
                end

                S_DONE: begin
                    done <= 1'b1;
                end

                default: begin
                    state <= S_READ;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ig_pixel_counter.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "ig_params.svh"

module ig_pixel_counter (
    input wire clk,
    input wire reset,
    input wire logic count_en,
    input wire logic count_clear,
    output ig_pkg::pixel_pos_t pos,
    output logic last
);

    import ig_pkg::*;

    logic x_end;
    logic y_end;

    // end of row and end of frame
    assign x_end = (pos.x == coord_t'(`IG_WIDTH - 1));
    assign y_end = (pos.y == coord_t'(`IG_HEIGHT - 1));

    // final pixel of the frame
    // flush sweep runs inside the last row, so same compare ends it
    assign last = x_end && y_end;

    // ------------------------------------------------------------------
    // raster stepping
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
        end else if (count_clear) begin
            // jump to start of last row
            pos.x <= '0;
            pos.y <= coord_t'(`IG_HEIGHT - 1);
            pos.addr <= addr_t'((`IG_HEIGHT - 1) * `IG_WIDTH);
        end else if (count_en) begin
            if (last) begin
                pos <= '0;
            end else begin
                pos.addr <= pos.addr + 1'b1;
                if (x_end) begin
                    // wrap x, next row
                    pos.x <= '0;
                    pos.y <= pos.y + 1'b1;
                end else begin
                    pos.x <= pos.x + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ig_pkg.sv ====
`default_nettype none

`include "ig_params.svh"

package ig_pkg;

    // ------------------------------------------------------------------
    // plain vectors
    // ------------------------------------------------------------------

    typedef logic [`IG_PIX_W-1:0] pixel_t;
    typedef logic signed [`IG_GRAD_W-1:0] grad_t;
    typedef logic [`IG_ADDR_W-1:0] addr_t;
    // x or y inside the frame
    typedef logic [7:0] coord_t;

    // sequencer phases
    typedef enum logic [1:0] {
        S_READ,
        S_DRAIN,
        S_FLUSH,
        S_DONE
    } ig_state_t;

    // ------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------

    // position of the address issued this cycle
    typedef struct packed {
        coord_t x;
        coord_t y;
        addr_t addr;
    } pixel_pos_t;

    // gradient memory word, gx in the upper half
    typedef struct packed {
        grad_t gx;
        grad_t gy;
    } grad_word_t;

    // one write to the gradient memory
    typedef struct packed {
        logic wr;
        addr_t addr;
        grad_word_t word;
    } grad_req_t;

endpackage

`default_nettype wire

// ==== verilog/ig_params.svh ====
`ifndef IG_PARAMS_SVH
`define IG_PARAMS_SVH

// ----------------------------------------------------------------------
// frame geometry
// ----------------------------------------------------------------------

// pixels per row
`define IG_WIDTH 256
// rows per frame
`define IG_HEIGHT 256

// ----------------------------------------------------------------------
// data path widths
// ----------------------------------------------------------------------

// both memories share one address width
`define IG_ADDR_W 16
`define IG_PIX_W 8
// one signed gradient component
`define IG_GRAD_W 10

`endif
